// ==== aes_core.f ====
+incdir+src
src/aes_block_pkg.sv
src/aes_field_pkg.sv
src/aes_key_step.sv
src/aes_round.sv
src/aes_core.sv
bench/aes_core_chk.sv
bench/aes_scoreboard.sv
bench/aes_tb.sv

// ==== Makefile ====
TOP = aes_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f aes_core.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f aes_core.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== bench/aes_tb.sv ====
module aes_tb;

    localparam int SEED = 29;
    localparam int NUM_BLOCKS = 2 + 1 + 20 + 200 + 8 + 12;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 40 + 200;

    // FIPS-197 appendix B and C.1
    localparam logic [127:0] VEC1_PLAIN  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [127:0] VEC1_KEY    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] VEC1_CIPHER = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam logic [127:0] VEC2_PLAIN  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] VEC2_KEY    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] VEC2_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic         in_ready;
    logic [127:0] in_plain;
    logic [127:0] in_key;
    logic         out_valid;
    logic         out_ready;
    logic [127:0] out_cipher;
    logic         known_en;
    logic [127:0] known_cipher;
    logic         lat_en;
    logic         rand_ready;
    int           err_cnt;
    int           pending;
    int           tests_ok;
    int           tests_bad;
    int           errs_before;
    integer       seed;
    integer       seed_rdy;

    aes_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_plain   (in_plain),
        .in_key     (in_key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_cipher (out_cipher)
    );

    aes_scoreboard u_sb (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_plain     (in_plain),
        .in_key       (in_key),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_cipher   (out_cipher),
        .known_en     (known_en),
        .known_cipher (known_cipher),
        .lat_en       (lat_en),
        .err_cnt      (err_cnt),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sink side, own stream next to the source seed
    initial begin
        seed_rdy = SEED + 1;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            out_ready <= rand_ready ? (($random(seed_rdy) & 1) != 0) : 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired, %0d output blocks are missing", pending);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    // Returns on the falling edge before the accepting edge
    task automatic send_block(logic [127:0] p, logic [127:0] k, logic kn,
                              logic [127:0] kc, logic gaps);
        @(posedge clk);
        while (gaps && (($random(seed) & 1) != 0)) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_plain <= p;
        in_key <= k;
        known_en <= kn;
        known_cipher <= kc;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
    endtask

    task automatic send_random(int n, logic gaps);
        for (int i = 0; i < n; i++) begin
            send_block({$random(seed), $random(seed), $random(seed), $random(seed)},
                       {$random(seed), $random(seed), $random(seed), $random(seed)},
                       1'b0, '0, gaps);
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        in_valid <= 1'b0;
        known_en <= 1'b0;
    endtask

    task automatic drain();
        @(negedge clk);
        while (pending != 0) @(negedge clk);
    endtask

    task automatic set_mode(logic lat, logic rnd);
        @(posedge clk);
        lat_en <= lat;
        rand_ready <= rnd;
    endtask

    task automatic finish_test(int num, string name);
        int total;
        total = err_cnt + u_dut.u_chk.fail_cnt;
        if (total == errs_before) begin
            $display("Test %0d %s: ok", num, name);
            tests_ok++;
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", num, name, total - errs_before);
            tests_bad++;
        end
        errs_before = total;
    endtask

    initial begin
        seed = SEED;
        rst = 1'b1;
        in_valid = 1'b0;
        in_plain = '0;
        in_key = '0;
        known_en = 1'b0;
        known_cipher = '0;
        lat_en = 1'b1;
        rand_ready = 1'b0;
        tests_ok = 0;
        tests_bad = 0;
        errs_before = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        set_mode(1'b1, 1'b0);
        send_block(VEC1_PLAIN, VEC1_KEY, 1'b1, VEC1_CIPHER, 1'b0);
        send_block(VEC2_PLAIN, VEC2_KEY, 1'b1, VEC2_CIPHER, 1'b0);
        go_idle();
        drain();
        finish_test(1, "known vectors");

        send_random(1, 1'b0);
        go_idle();
        drain();
        finish_test(2, "latency");

        send_random(20, 1'b0);
        go_idle();
        drain();
        finish_test(3, "throughput");

        set_mode(1'b0, 1'b1);
        send_random(200, 1'b1);
        go_idle();
        drain();
        finish_test(4, "back-pressure");

        // Reset with blocks still in flight
        send_random(8, 1'b1);
        @(posedge clk);
        in_valid <= 1'b0;
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        send_random(12, 1'b1);
        go_idle();
        drain();
        finish_test(5, "reset mid-stream");

        $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== bench/aes_scoreboard.sv ====
`include "aes_cfg.svh"

module aes_scoreboard
    import aes_block_pkg::*;
    import aes_field_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  logic         in_ready,
    input  block_t       in_plain,
    input  block_t       in_key,
    input  logic         out_valid,
    input  logic         out_ready,
    input  block_t       out_cipher,
    input  logic         known_en,
    input  logic [127:0] known_cipher,
    input  logic         lat_en,
    output int           err_cnt,
    output int           pending
);

    localparam int LATENCY = `AES_ROUNDS + 1;

    logic [7:0]   sbox_tab [0:255];
    logic [127:0] exp_q [$];
    int           acc_q [$];
    logic [127:0] exp_val;
    int           lat;
    int           cyc = 0;
    int           errs = 0;
    int           pend = 0;

    assign err_cnt = errs;
    assign pending = pend;

    // S-box table walked over the generator 3 and its inverse
    initial begin
        logic [7:0] p;
        logic [7:0] q;
        p = 8'h01;
        q = 8'h01;
        do begin
            p = p ^ {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
            q = q ^ {q[6:0], 1'b0};
            q = q ^ {q[5:0], 2'b00};
            q = q ^ {q[3:0], 4'h0};
            if (q[7]) begin
                q = q ^ 8'h09;
            end
            sbox_tab[p] = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]}
                        ^ {q[3:0], q[7:4]} ^ 8'h63;
        end while (p != 8'h01);
        sbox_tab[0] = 8'h63;
    end

    function automatic logic [7:0] times_two(logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference AES-128, state byte 0 in the top bits
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [127:0] aes128_ref(logic [127:0] plain, logic [127:0] key);
        logic [7:0]   s [0:15];
        logic [7:0]   t [0:15];
        logic [7:0]   k [0:15];
        logic [31:0]  tmp;
        logic [7:0]   rc;
        logic [127:0] res;
        rc = 8'h01;
        for (int i = 0; i < 16; i++) begin
            k[i] = key[127 - 8*i -: 8];
            s[i] = plain[127 - 8*i -: 8] ^ k[i];
        end
        for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++) begin
            tmp = {sbox_tab[k[13]] ^ rc, sbox_tab[k[14]], sbox_tab[k[15]], sbox_tab[k[12]]};
            for (int i = 0; i < 4; i++) begin
                k[i] = k[i] ^ tmp[31 - 8*i -: 8];
            end
            for (int i = 4; i < 16; i++) begin
                k[i] = k[i] ^ k[i-4];
            end
            rc = times_two(rc);
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    t[c*4 + r] = sbox_tab[s[((c + r) % 4) * 4 + r]];
                end
            end
            // 2 3 1 1 rows, rotated per output row
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    if (rnd < `AES_ROUNDS) begin
                        s[c*4 + r] = times_two(t[c*4 + r]) ^ times_two(t[c*4 + (r+1) % 4])
                                   ^ t[c*4 + (r+1) % 4] ^ t[c*4 + (r+2) % 4]
                                   ^ t[c*4 + (r+3) % 4];
                    end else begin
                        s[c*4 + r] = t[c*4 + r];
                    end
                    s[c*4 + r] = s[c*4 + r] ^ k[c*4 + r];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            res[127 - 8*i -: 8] = s[i];
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Capture and compare
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            acc_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output at time %0t with no block outstanding", $time);
                    errs++;
                end else begin
                    exp_val = exp_q.pop_front();
                    lat = cyc - acc_q.pop_front();
                    if (out_cipher !== exp_val) begin
                        $display("** Error at %0t: out_cipher expected %h, got %h",
                                 $time, exp_val, out_cipher);
                        errs++;
                    end
                    if (lat_en && lat != LATENCY) begin
                        $display("** Error at %0t: out_valid latency expected %0d, got %0d",
                                 $time, LATENCY, lat);
                        errs++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(known_en ? known_cipher : aes128_ref(in_plain, in_key));
                acc_q.push_back(cyc);
            end
        end
        pend = exp_q.size();
        cyc = cyc + 1;
    end

endmodule

// ==== bench/aes_core_chk.sv ====
module aes_core_chk (
    input logic         clk,
    input logic         rst,
    input logic         in_ready,
    input logic         out_valid,
    input logic         out_ready,
    input logic [127:0] out_cipher
);

    int fail_cnt = 0;

    // Valid chain cleared by reset
    a_reset_clears: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid is still high in the cycle after reset");
            fail_cnt++;
        end

    // Stalled output holds its block
    a_output_holds: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_cipher)))
        else begin
            $error("output block changed or vanished while stalled");
            fail_cnt++;
        end

    a_ready_when_empty: assert property (@(posedge clk) !out_valid |-> in_ready)
        else begin
            $error("in_ready is low while the output is empty");
            fail_cnt++;
        end

endmodule

bind aes_core aes_core_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_cipher (out_cipher)
);

// ==== src/aes_core.sv ====
`include "aes_cfg.svh"

module aes_core
    import aes_block_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    output logic   in_ready,
    input  block_t in_plain,
    input  block_t in_key,
    output logic   out_valid,
    input  logic   out_ready,
    output block_t out_cipher
);

    // Pipeline moves as one, stalls only when the output is full and blocked
    logic adv;

    // Bit 0 for the whitening register, bit r for round stage r
    logic [`AES_ROUNDS:0] vld;

    // Whitening registers
    block_t white_state;
    block_t white_key;

    // Index r is the output of stage r, index 0 the whitening register
    block_t state_q [0:`AES_ROUNDS];
    block_t key_q   [0:`AES_ROUNDS-1];

    assign adv       = out_ready | ~out_valid;
    assign in_ready  = adv;
    assign out_valid = vld[`AES_ROUNDS];

    ////////////////////////////////////////////////////////////////////////////
    // Valid chain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else if (adv) begin
            vld <= {vld[`AES_ROUNDS-1:0], in_valid};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input whitening, initial AddRoundKey with the cipher key
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (adv) begin
            white_state <= in_plain ^ in_key;
            white_key   <= in_key;
        end
    end

    assign state_q[0] = white_state;
    assign key_q[0]   = white_key;

    ////////////////////////////////////////////////////////////////////////////
    // Round stages
    ////////////////////////////////////////////////////////////////////////////

    for (genvar r = 1; r <= `AES_ROUNDS; r++) begin : g_stage
        block_t rkey;

        // Last key step has no stage after it to feed
        if (r < `AES_ROUNDS) begin : g_key
            aes_key_step #(.ROUND(r)) u_key (
                .clk       (clk),
                .en        (adv),
                .key_in    (key_q[r-1]),
                .round_key (rkey),
                .key_out   (key_q[r])
            );
        end else begin : g_key_last
            aes_key_step #(.ROUND(r)) u_key (
                .clk       (clk),
                .en        (adv),
                .key_in    (key_q[r-1]),
                .round_key (rkey),
                .key_out   ()
            );
        end

        aes_round #(.ROUND(r)) u_round (
            .clk       (clk),
            .en        (adv),
            .state_in  (state_q[r-1]),
            .round_key (rkey),
            .state_out (state_q[r])
        );
    end

    assign out_cipher = state_q[`AES_ROUNDS];

endmodule

// ==== src/aes_round.sv ====
`include "aes_cfg.svh"

module aes_round
    import aes_block_pkg::*;
    import aes_field_pkg::*;
#(
    parameter int ROUND = 1
) (
    input  logic   clk,
    input  logic   en,
    input  block_t state_in,
    input  block_t round_key,
    output block_t state_out
);

    block_t shifted;
    block_t mixed;
    block_t next_state;

    // One column times the fixed MixColumns matrix
    // b_r = a_r ^ t ^ 2*(a_r ^ a_r+1), t the XOR of all four bytes
    function automatic word_t mix_col(word_t w);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        byte_t t;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        t = a0 ^ a1 ^ a2 ^ a3;
        return {a0 ^ t ^ xtime(a0 ^ a1),
                a1 ^ t ^ xtime(a1 ^ a2),
                a2 ^ t ^ xtime(a2 ^ a3),
                a3 ^ t ^ xtime(a3 ^ a0)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // SubBytes and ShiftRows
    ////////////////////////////////////////////////////////////////////////////

    // Row r of column c comes from column c+r, same row
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted.bytes[c*4 + r] = sbox(state_in.bytes[((c + r) % 4) * 4 + r]);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // MixColumns and AddRoundKey
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            // Final round skips MixColumns
            if (ROUND == `AES_ROUNDS) begin
                mixed.col[c] = shifted.col[c];
            end else begin
                mixed.col[c] = mix_col(shifted.col[c]);
            end
            next_state.col[c] = mixed.col[c] ^ round_key.col[c];
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            state_out <= next_state;
        end
    end

endmodule

// ==== src/aes_key_step.sv ====
`include "aes_cfg.svh"

module aes_key_step
    import aes_block_pkg::*;
    import aes_field_pkg::*;
#(
    parameter int ROUND = 1
) (
    input  logic   clk,
    input  logic   en,
    input  block_t key_in,
    output block_t round_key,
    output block_t key_out
);

    localparam byte_t RCON = rcon_for(ROUND);

    word_t last;
    word_t temp;

    // RotWord then SubWord on the last column
    assign last = key_in.col[3];
    assign temp = {sbox(last[23:16]), sbox(last[15:8]), sbox(last[7:0]), sbox(last[31:24])}
                ^ {RCON, {(`AES_WORD_W - `AES_BYTE_W){1'b0}}};

    // Each new column feeds the next one
    always_comb begin
        round_key.col[0] = key_in.col[0] ^ temp;
        for (int c = 1; c < 4; c++) begin
            round_key.col[c] = key_in.col[c] ^ round_key.col[c-1];
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            key_out <= round_key;
        end
    end

endmodule

// ==== src/aes_field_pkg.sv ====
`include "aes_cfg.svh"

package aes_field_pkg;

    import aes_block_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // GF(2^8) arithmetic, reduction polynomial x^8 + x^4 + x^3 + x + 1
    ////////////////////////////////////////////////////////////////////////////

    function automatic byte_t xtime(byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic byte_t gmul(byte_t a, byte_t b);
        byte_t acc;
        byte_t x;
        acc = '0;
        x = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ x;
            end
            x = xtime(x);
        end
        return acc;
    endfunction

    // Inverse as a^254, built from the squares a^2 .. a^128
    // Zero maps to zero, as the S-box needs
    function automatic byte_t ginv(byte_t a);
        byte_t acc;
        byte_t sq;
        acc = 8'h01;
        sq = a;
        for (int i = 1; i < `AES_BYTE_W; i++) begin
            sq = gmul(sq, sq);
            acc = gmul(acc, sq);
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Cipher building blocks
    ////////////////////////////////////////////////////////////////////////////

    // Inverse followed by the affine map
    function automatic byte_t sbox(byte_t a);
        byte_t inv;
        byte_t acc;
        inv = ginv(a);
        acc = inv;
        for (int i = 1; i <= 4; i++) begin
            acc = acc ^ ((inv << i) | (inv >> (`AES_BYTE_W - i)));
        end
        return acc ^ 8'h63;
    endfunction

    // 01, 02, 04 .. 80, 1b, 36 for rounds 1 to 10
    function automatic byte_t rcon_for(int round);
        byte_t rc;
        rc = 8'h01;
        for (int i = 2; i <= `AES_ROUNDS; i++) begin
            if (i <= round) begin
                rc = xtime(rc);
            end
        end
        return rc;
    endfunction

endpackage

// ==== src/aes_block_pkg.sv ====
`include "aes_cfg.svh"

package aes_block_pkg;

    typedef logic [`AES_BYTE_W-1:0] byte_t;

    // Four bytes of one column, row 0 in the top byte
    typedef logic [`AES_WORD_W-1:0] word_t;

    // One 128-bit state
    // Column 0 and byte 0 both sit in the most significant position, so
    // byte n of the column view is row n%4 of column n/4
    typedef union packed {
        word_t [0:`AES_BLOCK_W/`AES_WORD_W-1] col;
        byte_t [0:`AES_BLOCK_W/`AES_BYTE_W-1] bytes;
    } block_t;

endpackage

// ==== src/aes_cfg.svh ====
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Cipher block, one full AES state
`define AES_BLOCK_W 128

// One state column
`define AES_WORD_W 32

// One state byte
`define AES_BYTE_W 8

// AES-128 round count
`define AES_ROUNDS 10

`endif
